// ==== common/fetch_pkg.sv ====
package fetch_pkg;

    localparam int ICACHE_INDEX_BITS = 5;
    localparam int ICACHE_LINES = 1 << ICACHE_INDEX_BITS;
    // the index starts at bit 1, so the tag holds everything above it.
    localparam int TAG_BITS = 32 - ICACHE_INDEX_BITS - 1;

    typedef logic [31:0] pc_t;
    typedef logic [31:0] inst_t;
    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [ICACHE_INDEX_BITS-1:0] index_t;

    // RV32I major opcodes.
    localparam logic [6:0] OP_JAL = 7'b1101111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JALR = 7'b1100111;

    // RVC funct3 codes of quadrant 1 for the first four and of quadrant 2 for jr.
    localparam logic [2:0] C_FUNCT_JAL = 3'b001;
    localparam logic [2:0] C_FUNCT_J = 3'b101;
    localparam logic [2:0] C_FUNCT_BEQZ = 3'b110;
    localparam logic [2:0] C_FUNCT_BNEZ = 3'b111;
    localparam logic [2:0] C_FUNCT_JR = 3'b100;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        WAIT_REDIRECT
    } fetch_state_t;

    typedef enum logic [1:0] {
        READY,
        SETUP,
        ACCESS
    } fill_state_t;

endpackage

// ==== common/icache_if.sv ====
`timescale 1ns/1ps

interface icache_if;
    import fetch_pkg::*;

    // a one-cycle lookup request from fetch.
    logic  req;
    pc_t   addr;

    // one-cycle answer from the cache with the 32 bits at addr.
    logic  resp_valid;
    inst_t resp_data;

    modport fetch (
        output req,
        output addr,
        input  resp_valid,
        input  resp_data
    );

    modport cache (
        input  req,
        input  addr,
        output resp_valid,
        output resp_data
    );

endinterface

// ==== icache/icache.sv ====
`timescale 1ns/1ps

module icache (
    input  logic             clk,
    input  logic             rst,
    input  fetch_pkg::inst_t prdata,
    input  logic             pready,
    icache_if.cache          cif,
    output logic             psel,
    output logic             penable,
    output fetch_pkg::pc_t   paddr
);
    import fetch_pkg::*;

    logic [ICACHE_LINES-1:0] valid;
    tag_t                    tags  [ICACHE_LINES];
    inst_t                   lines [ICACHE_LINES];

    fill_state_t state;
    index_t      req_idx;
    index_t      fill_idx;
    tag_t        req_tag;
    logic        hit;
    logic        fill_done;

    assign req_idx = cif.addr[ICACHE_INDEX_BITS:1];
    assign req_tag = cif.addr[31:ICACHE_INDEX_BITS+1];
    assign hit = valid[req_idx] && (tags[req_idx] == req_tag);

    // the fill address is held in paddr for the whole APB transfer.
    assign fill_idx = paddr[ICACHE_INDEX_BITS:1];
    assign fill_done = (state == ACCESS) && pready;

    assign psel = (state != READY);
    assign penable = (state == ACCESS);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= READY;
            valid <= '0;
            cif.resp_valid <= 1'b0;
        end else begin
            cif.resp_valid <= 1'b0;
            case (state)
                READY: begin
                    if (cif.req) begin
                        if (hit) begin
                            cif.resp_valid <= 1'b1;
                        end else begin
                            state <= SETUP;
                        end
                    end
                end
                SETUP: begin
                    state <= ACCESS;
                end
                ACCESS: begin
                    if (pready) begin
                        state <= READY;
                        valid[fill_idx] <= 1'b1;
                        cif.resp_valid <= 1'b1;
                    end
                end
                default: begin
                    state <= READY;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == READY && cif.req) begin
            cif.resp_data <= lines[req_idx];
            if (!hit) begin
                paddr <= cif.addr;
            end
        end
        // memory data goes to the entry and to the requester at once.
        if (fill_done) begin
            tags[fill_idx] <= paddr[31:ICACHE_INDEX_BITS+1];
            lines[fill_idx] <= prdata;
            cif.resp_data <= prdata;
        end
    end

    // fetch waits for every answer, so a lookup never arrives during a fill.
    no_req_during_fill: assert property (
        @(posedge clk) disable iff (rst)
        cif.req |-> (state == READY)
    );

    apb_addr_stable: assert property (
        @(posedge clk) disable iff (rst)
        psel |=> !psel || $stable(paddr)
    );

endmodule

// ==== src/predecode.sv ====
`timescale 1ns/1ps

module predecode (
    input  fetch_pkg::inst_t inst,
    input  fetch_pkg::pc_t   pc,
    output fetch_pkg::pc_t   next_pc,
    output logic             indirect
);
    import fetch_pkg::*;

    logic is_rvc;
    pc_t  imm_j;
    pc_t  imm_b;
    pc_t  imm_cj;
    pc_t  imm_cb;
    logic is_c_jr;

    assign is_rvc = (inst[1:0] != 2'b11);

    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

    // the compressed immediates are scattered across the halfword.
    assign imm_cj = {{21{inst[12]}}, inst[8], inst[10:9], inst[6], inst[7],
                     inst[2], inst[11], inst[5:3], 1'b0};
    assign imm_cb = {{24{inst[12]}}, inst[6:5], inst[2], inst[11:10],
                     inst[4:3], 1'b0};

    // c.jr and c.jalr have rs2 zero and a nonzero rs1, which sets c.ebreak apart.
    assign is_c_jr = (inst[1:0] == 2'b10) && (inst[15:13] == C_FUNCT_JR) &&
                     (inst[6:2] == 5'd0) && (inst[11:7] != 5'd0);

    always_comb begin
        indirect = 1'b0;
        next_pc = pc + (is_rvc ? 32'd2 : 32'd4);
        if (!is_rvc) begin
            case (inst[6:0])
                OP_JAL: begin
                    next_pc = pc + imm_j;
                end
                OP_BRANCH: begin
                    next_pc = pc + imm_b;
                end
                OP_JALR: begin
                    indirect = 1'b1;
                end
                default: begin
                    next_pc = pc + 32'd4;
                end
            endcase
        end else if (inst[1:0] == 2'b01) begin
            // quadrant 1 holds the direct compressed jumps and branches.
            case (inst[15:13])
                C_FUNCT_J, C_FUNCT_JAL: begin
                    next_pc = pc + imm_cj;
                end
                C_FUNCT_BEQZ, C_FUNCT_BNEZ: begin
                    next_pc = pc + imm_cb;
                end
                default: begin
                    next_pc = pc + 32'd2;
                end
            endcase
        end else if (is_c_jr) begin
            indirect = 1'b1;
        end
    end

endmodule

// ==== src/fetch_ctrl.sv ====
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic             clk,
    input  logic             rst,
    input  logic             redirect_valid,
    input  fetch_pkg::pc_t   redirect_pc,
    input  logic             iq_full,
    input  logic             lsb_full,
    icache_if.fetch          fc,
    output logic             inst_valid,
    output fetch_pkg::inst_t inst,
    output fetch_pkg::pc_t   inst_pc
);
    import fetch_pkg::*;

    fetch_state_t state;
    pc_t          pc_q;
    pc_t          next_pc;
    logic         indirect;
    logic         discard;
    logic         stall;
    logic         accept;

    predecode predecode_i (
        .inst     (fc.resp_data),
        .pc       (pc_q),
        .next_pc  (next_pc),
        .indirect (indirect)
    );

    assign stall = iq_full || lsb_full;

    // no lookup while an abandoned response is still on its way back.
    assign fc.req = (state == IDLE) && !stall && !discard && !redirect_valid;
    assign fc.addr = pc_q;

    // a redirect in the same cycle as the response throws the response away.
    assign accept = (state == LOOKUP) && fc.resp_valid && !redirect_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            pc_q <= '0;
            discard <= 1'b0;
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= accept;

            if (redirect_valid && state == LOOKUP && !fc.resp_valid) begin
                discard <= 1'b1;
            end else if (fc.resp_valid) begin
                discard <= 1'b0;
            end

            if (redirect_valid) begin
                state <= IDLE;
                pc_q <= redirect_pc;
            end else begin
                case (state)
                    IDLE: begin
                        if (fc.req) begin
                            state <= LOOKUP;
                        end
                    end
                    LOOKUP: begin
                        if (fc.resp_valid) begin
                            pc_q <= next_pc;
                            state <= indirect ? WAIT_REDIRECT : IDLE;
                        end
                    end
                    default: begin
                        state <= WAIT_REDIRECT;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            inst <= fc.resp_data;
            inst_pc <= pc_q;
        end
    end

    // a lookup never overlaps a response coming back from the cache.
    req_only_when_idle: assert property (
        @(posedge clk) disable iff (rst)
        fc.req |-> !fc.resp_valid
    );

    // fetch has stopped, so no answer from the cache can still be on its way.
    no_resp_while_waiting: assert property (
        @(posedge clk) disable iff (rst)
        (state == WAIT_REDIRECT) |-> !fc.resp_valid
    );

endmodule

// ==== src/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             redirect_valid,
    input  fetch_pkg::pc_t   redirect_pc,
    input  logic             iq_full,
    input  logic             lsb_full,
    input  fetch_pkg::inst_t prdata,
    input  logic             pready,
    output logic             psel,
    output logic             penable,
    output fetch_pkg::pc_t   paddr,
    output logic             inst_valid,
    output fetch_pkg::inst_t inst,
    output fetch_pkg::pc_t   inst_pc
);

    icache_if cache_bus ();

    fetch_ctrl fetch_ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .iq_full        (iq_full),
        .lsb_full       (lsb_full),
        .fc             (cache_bus.fetch),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .inst_pc        (inst_pc)
    );

    icache icache_i (
        .clk     (clk),
        .rst     (rst),
        .prdata  (prdata),
        .pready  (pready),
        .cif     (cache_bus.cache),
        .psel    (psel),
        .penable (penable),
        .paddr   (paddr)
    );

endmodule

// ==== bench/apb_imem.sv ====
`timescale 1ns/1ps

module apb_imem (
    input  logic             clk,
    input  logic             rst,
    input  logic             psel,
    input  logic             penable,
    input  fetch_pkg::pc_t   paddr,
    output fetch_pkg::inst_t prdata,
    output logic             pready,
    output int               setup_count
);
    logic [15:0] mem [2048];
    logic [31:0] rng;
    logic [31:0] rng_next;
    logic [1:0]  wait_left;
    logic [10:0] idx;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    initial begin
        // halfwords that no test loads hold a pattern built from the whole address.
        for (int i = 0; i < 2048; i++) begin
            mem[i] = 16'(i * 16'h9e37) ^ 16'h5a5a;
        end
    end

    // the memory answers with the 32 bits that start at any halfword.
    assign idx = paddr[11:1];
    assign prdata = {mem[idx + 11'd1], mem[idx]};
    assign rng_next = xorshift(rng);
    assign pready = psel && penable && (wait_left == 2'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            rng <= 32'h2508;
            wait_left <= 2'd0;
            setup_count <= 0;
        end else if (psel && !penable) begin
            rng <= rng_next;
            wait_left <= rng_next[1:0];
            setup_count <= setup_count + 1;
        end else if (psel && penable && wait_left != 2'd0) begin
            wait_left <= wait_left - 2'd1;
        end
    end

endmodule

// ==== bench/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb;
    import fetch_pkg::*;

    localparam int MAX_TESTS = 8;
    localparam int QUIET_CYCLES = 16;

    logic  clk = 1'b0;
    logic  rst;
    logic  redirect_valid;
    pc_t   redirect_pc;
    logic  iq_full;
    logic  lsb_full;
    inst_t prdata;
    logic  pready;
    logic  psel;
    logic  penable;
    pc_t   paddr;
    logic  inst_valid;
    inst_t inst;
    pc_t   inst_pc;
    int    setup_count;

    logic [127:0] t_name [MAX_TESTS];
    int    t_reads [MAX_TESTS];
    int    x_after [MAX_TESTS];
    int    x_delay [MAX_TESTS];
    pc_t   x_pc [MAX_TESTS];
    int    s_after [MAX_TESTS];
    int    s_len [MAX_TESTS];
    int    s_sel [MAX_TESTS];
    int    e_test [$];
    pc_t   e_pc [$];
    inst_t e_inst [$];
    int    n_tests;
    int    passed;
    int    failed;

    always #50 clk = ~clk;

    fetch_top dut_i (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .iq_full        (iq_full),
        .lsb_full       (lsb_full),
        .prdata         (prdata),
        .pready         (pready),
        .psel           (psel),
        .penable        (penable),
        .paddr          (paddr),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .inst_pc        (inst_pc)
    );

    apb_imem mem_i (
        .clk         (clk),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .paddr       (paddr),
        .prdata      (prdata),
        .pready      (pready),
        .setup_count (setup_count)
    );

    function automatic logic read_tests();
        int fd;
        int code;
        logic [127:0] kw;
        logic [7:0] key;
        logic [1023:0] line;
        pc_t a;
        inst_t d;
        fd = $fopen("bench/fetch_tests.txt", "r");
        if (fd == 0) begin
            return 1'b0;
        end
        n_tests = 0;
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", kw);
            if (code == 1) begin
                key = kw[7:0];
                case (key)
                    "#": code = $fgets(line, fd);
                    "t": begin
                        code = $fscanf(fd, "%s", t_name[n_tests]);
                        t_reads[n_tests] = -1;
                        x_after[n_tests] = -1;
                        x_delay[n_tests] = 0;
                        s_after[n_tests] = -1;
                        s_len[n_tests] = 0;
                        n_tests++;
                    end
                    "e": begin
                        code = $fscanf(fd, "%h %h", a, d);
                        e_test.push_back(n_tests - 1);
                        e_pc.push_back(a);
                        e_inst.push_back(d);
                    end
                    "r": code = $fscanf(fd, "%d", t_reads[n_tests - 1]);
                    "x": code = $fscanf(fd, "%d %d %h", x_after[n_tests - 1],
                                        x_delay[n_tests - 1], x_pc[n_tests - 1]);
                    "s": code = $fscanf(fd, "%d %d %d", s_after[n_tests - 1],
                                        s_len[n_tests - 1], s_sel[n_tests - 1]);
                    default: $display("unknown keyword in the tests file: %0s", kw);
                endcase
            end
        end
        $fclose(fd);
        return n_tests > 0;
    endfunction

    task automatic stop_on_timeout(input int cycles);
        repeat (cycles) @(posedge clk);
        $display("timeout after %0d cycles, expected instructions never arrived", cycles);
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic run_test(input int t);
        int first;
        int n_exp;
        int got;
        int quiet;
        int wait_left;
        int st_left;
        int stall_outs;
        int errs;
        logic rd_done;
        logic st_done;
        pc_t a;
        inst_t mask;
        first = -1;
        n_exp = 0;
        foreach (e_test[i]) begin
            if (e_test[i] == t) begin
                if (first < 0) begin
                    first = i;
                end
                n_exp++;
            end
        end
        @(posedge clk);
        rst <= 1'b1;
        redirect_valid <= 1'b0;
        iq_full <= 1'b0;
        lsb_full <= 1'b0;
        // every expected instruction is also the memory image along its path.
        for (int i = first; i < first + n_exp; i++) begin
            a = e_pc[i];
            mem_i.mem[a[11:1]] = e_inst[i][15:0];
            if (e_inst[i][1:0] == 2'b11) begin
                a = a + 32'd2;
                mem_i.mem[a[11:1]] = e_inst[i][31:16];
            end
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        got = 0;
        quiet = 0;
        errs = 0;
        stall_outs = 0;
        st_left = 0;
        wait_left = x_delay[t];
        rd_done = 1'b0;
        st_done = 1'b0;
        while (quiet < QUIET_CYCLES) begin
            @(negedge clk);
            if (inst_valid) begin
                if (iq_full || lsb_full) begin
                    stall_outs++;
                end
                assert (got < n_exp) else begin
                    $display("extra instruction at pc %h in test %0s", inst_pc, t_name[t]);
                    errs++;
                end
                if (got < n_exp) begin
                    // a compressed instruction only defines the low halfword.
                    mask = (e_inst[first + got][1:0] == 2'b11) ? 32'hffffffff : 32'h0000ffff;
                    assert (inst_pc == e_pc[first + got]) else begin
                        $display("ERROR t=%0t inst_pc expected %h got %h",
                                 $time, e_pc[first + got], inst_pc);
                        errs++;
                    end
                    assert ((inst & mask) == e_inst[first + got]) else begin
                        $display("ERROR t=%0t inst expected %h got %h",
                                 $time, e_inst[first + got], inst & mask);
                        errs++;
                    end
                    got++;
                end
            end
            if (got == n_exp) begin
                quiet++;
            end
            @(posedge clk);
            redirect_valid <= 1'b0;
            if (x_after[t] >= 0 && !rd_done && got == x_after[t]) begin
                if (wait_left == 0) begin
                    redirect_valid <= 1'b1;
                    redirect_pc <= x_pc[t];
                    rd_done = 1'b1;
                end else begin
                    wait_left--;
                end
            end
            if (s_after[t] >= 0 && !st_done && got == s_after[t]) begin
                st_left = s_len[t];
                st_done = 1'b1;
            end
            iq_full <= (st_left > 0) && s_sel[t][0];
            lsb_full <= (st_left > 0) && s_sel[t][1];
            if (st_left > 0) begin
                st_left--;
            end
        end
        assert (stall_outs <= 1) else begin
            $display("more than one instruction came out during the stall in test %0s",
                     t_name[t]);
            errs++;
        end
        if (t_reads[t] >= 0) begin
            assert (setup_count == t_reads[t]) else begin
                $display("ERROR t=%0t setup_count expected %0d got %0d",
                         $time, t_reads[t], setup_count);
                errs++;
            end
        end
        if (errs == 0) begin
            passed++;
            $display("test %0s: ok, %0d instructions", t_name[t], got);
        end else begin
            failed++;
            $display("test %0s: failed with %0d errors", t_name[t], errs);
        end
    endtask

    initial begin
        int limit;
        rst = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc = '0;
        iq_full = 1'b0;
        lsb_full = 1'b0;
        passed = 0;
        failed = 0;
        if (!read_tests()) begin
            $display("could not read any test from bench/fetch_tests.txt");
            $display("TESTS FAILED");
            $finish;
        end else begin
            limit = 100 + e_pc.size() * 20;
            for (int t = 0; t < n_tests; t++) begin
                limit += x_delay[t] + s_len[t] + QUIET_CYCLES + 4;
            end
            fork
                stop_on_timeout(limit);
            join_none
            for (int t = 0; t < n_tests; t++) begin
                run_test(t);
            end
            $display("%0d tests passed, %0d tests failed", passed, failed);
            if (failed == 0) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

// ==== bench/fetch_tests.txt ====
# t name | e pc inst (expected in order, also loaded into memory) | r apb reads
# x after_n delay_cycles target_pc (redirect) | s after_n cycles sel (1 iq_full, 2 lsb_full)
t straight
e 0 00100093
e 4 00200113
e 8 00300193
e c 00208233
e 10 00008067
r 5
t mixed_rvc
e 0 4085
e 2 00100093
e 6 0001
e 8 8106
e a 00208233
e e 8082
r 6
t taken_jumps
e 0 0200006f
e 20 c401
e 28 fe0004e3
e 10 e015
e 34 bff5
e 30 8082
r 6
t indirect_wait
e 0 00100093
e 4 00008067
e 40 0001
e 42 8082
x 2 10 40
r 4
t loop_redirect
e 0 a801
e 10 00108093
e 14 0001
e 16 fc6d
e 10 00108093
e 14 0001
e 16 fc6d
e 30 8082
x 7 0 30
r 5
t iq_stall
e 0 00100093
e 4 00200113
e 8 00300193
e c 00008067
s 1 12 1
r 4
t lsb_stall
e 0 00100093
e 4 00200113
e 8 00300193
e c 00008067
s 2 15 2
r 4

// ==== compile.f ====
common/fetch_pkg.sv
common/icache_if.sv
icache/icache.sv
src/predecode.sv
src/fetch_ctrl.sv
src/fetch_top.sv
bench/apb_imem.sv
bench/fetch_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module fetch_tb \
    -Mdir obj_dir -o fetch_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/fetch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" sim.log; then
    exit 0
fi
exit 1
